/* Makefile */
TOP = tb_dma_probe

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f dma_probe.f -o V$(TOP)

run: compile
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "Simulation completed successfully" sim.log

clean:
	rm -rf obj_dir sim.log

/* dma_probe.f */
verilog/dma_probe_pkg.sv
verilog/dma_probe_regs.sv
verilog/dma_probe_seq.sv
verilog/bank_arbiter.sv
verilog/data_ram.sv
verilog/dma_probe_top.sv
sim/dma_probe_chk.sv
sim/dma_probe_monitor.sv
sim/tb_dma_probe.sv

/* sim/dma_probe_chk.sv */
`timescale 1ns/100ps
`default_nettype none

module dma_probe_chk import dma_probe_pkg::*; (
  input wire        mclk,
  input wire        puc_rst,
  input seq_state_t state,
  input wire        dma_en,
  input wire        cnt_wr
);

  int run;    // Request cycles so far in this burst

  always_ff @(posedge mclk or posedge puc_rst) begin
    if (puc_rst) run <= 0;
    else run <= dma_en ? run + 1 : 0;
  end

  // Burst only opens out of the delay countdown
  a_en_from_wait: assert property (@(posedge mclk) disable iff (puc_rst)
    $rose(dma_en) |-> $past(state) == SEQ_WAIT) else $error("dma_en rose without a delay phase");

  a_burst_max: assert property (@(posedge mclk) disable iff (puc_rst)
    dma_en |-> run < BURST_LEN) else $error("burst longer than BURST_LEN");

  a_burst_len: assert property (@(posedge mclk) disable iff (puc_rst)
    $fell(dma_en) |-> ($past(run) == BURST_LEN - 1) || $past(cnt_wr))
    else $error("burst ended early without a CNT write");

  a_rst_idle: assert property (@(posedge mclk) puc_rst |-> !dma_en)
    else $error("dma_en high during reset");

endmodule

bind dma_probe_seq dma_probe_chk i_chk (
  .mclk(mclk), .puc_rst(puc_rst), .state(state), .dma_en(dma.en), .cnt_wr(cfg.cnt_wr)
);

`default_nettype wire

/* sim/dma_probe_monitor.sv */
`timescale 1ns/100ps
`default_nettype none

module dma_probe_monitor import dma_probe_pkg::*; (
  input  wire        mclk,
  input  wire        puc_rst,
  input  per_addr_t  per_addr,
  input  word_t      per_din,
  input  wire        per_en,
  input  wire  [1:0] per_we,
  input  word_t      per_dout,
  input  cpu_req_t   cpu,
  input  word_t      cpu_dout,
  input  wire        dma_en,
  input  waddr_t     dma_addr,
  output int         err_cnt
);

  localparam per_addr_t W_BASE = per_addr_t'(BASE_ADDR >> 1);

  word_t  exp_addr, exp_cnt, rd_exp;   // Register model
  trace_t exp_trace;
  int     wait_left, burst_left;
  logic   rd_pend;
  word_t  shadow [waddr_t];             // CPU view of the RAM

  task automatic mismatch(input string name, input word_t got, input word_t exp);
    $display("CHECK FAILED %s: got 0x%04h expected 0x%04h", name, got, exp);
    err_cnt++;
  endtask

  initial err_cnt = 0;

  always @(posedge mclk) begin
    if (puc_rst) begin
      exp_addr   = '0;
      exp_cnt    = '0;
      exp_trace  = '0;
      wait_left  = 0;
      burst_left = 0;
      rd_pend    = 1'b0;
    end else begin
      // ==================== Checks on this cycle
      if (dma_en !== (burst_left > 0)) begin
        mismatch("dma_en", word_t'(dma_en), word_t'(burst_left > 0));
      end
      if (dma_en && dma_addr !== exp_addr[15:1]) mismatch("dma_addr", dma_addr, exp_addr[15:1]);
      if (rd_pend && cpu_dout !== rd_exp) mismatch("cpu_dout", cpu_dout, rd_exp);
      if (per_en && per_we == 2'b00) begin
        if (per_addr == W_BASE) begin
          if (per_dout !== exp_addr) mismatch("per_dout ADDR", per_dout, exp_addr);
        end else if (per_addr == W_BASE + 1) begin
          if (wait_left == 0 && burst_left == 0 && per_dout !== exp_cnt)
            mismatch("per_dout CNT", per_dout, exp_cnt);
        end else if (per_addr == W_BASE + 2) begin
          if (per_dout !== exp_trace) mismatch("per_dout TRACE", per_dout, exp_trace);
        end else if (per_dout !== 16'h0000) begin
          mismatch("per_dout", per_dout, 16'h0000);   // Unselected or hole
        end
      end
      // ==================== Model update for this edge
      rd_pend = cpu.en && cpu.we == 2'b00 && shadow.exists(cpu.addr);
      if (rd_pend) rd_exp = shadow[cpu.addr];
      if (cpu.en && cpu.we != 2'b00) shadow[cpu.addr] = cpu.din;   // Full word writes only
      if (per_en && per_we != 2'b00 && per_addr == W_BASE) exp_addr = per_din;
      if (per_en && per_we != 2'b00 && per_addr == W_BASE + 1) begin
        exp_cnt    = per_din;   // Restart
        wait_left  = int'(per_din);
        burst_left = 0;
      end else if (burst_left > 0) begin
        exp_trace = {exp_trace[BURST_LEN-2:0], cpu.en && (cpu.addr[0] == exp_addr[1])};
        burst_left--;
        if (burst_left == 0) exp_cnt = 16'hffff;
      end else if (wait_left > 0) begin
        wait_left--;
        if (wait_left == 0) burst_left = BURST_LEN;
      end
    end
  end

endmodule

`default_nettype wire

/* sim/tb_dma_probe.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_dma_probe import dma_probe_pkg::*; ();

  localparam int ROWS      = 8;
  localparam int MAX_N     = 8;
  localparam int RST_CYC   = 8;
  localparam int EXTRA_CYC = 80;    // Reset reads, decode holes, CNT zero case
  localparam int LIMIT     = ROWS * (MAX_N + BURST_LEN + 20) + RST_CYC + EXTRA_CYC;

  // Peripheral word addresses of the registers
  localparam per_addr_t A_ADDR  = per_addr_t'((BASE_ADDR + REG_ADDR) >> 1);
  localparam per_addr_t A_CNT   = per_addr_t'((BASE_ADDR + REG_CNT) >> 1);
  localparam per_addr_t A_TRACE = per_addr_t'((BASE_ADDR + REG_TRACE) >> 1);

  typedef struct packed {
    word_t       target;   // Byte address
    logic [3:0]  delay;
    logic [15:0] mask;     // Bit 15 on the first burst cycle
    logic        bank;     // CPU bank during the burst
  } row_t;

  logic      mclk;
  logic      puc_rst;
  per_addr_t per_addr;
  word_t     per_din;
  logic      per_en;
  logic [1:0] per_we;
  word_t     per_dout;
  cpu_req_t  cpu;
  word_t     cpu_dout;
  logic      dma_en;
  waddr_t    dma_addr;
  int        mon_errs;
  int        tb_errs;
  int        cycles;
  int        seed;
  row_t      rows [ROWS];

  dma_probe_top i_dut (
    .mclk(mclk), .puc_rst(puc_rst), .per_addr(per_addr), .per_din(per_din),
    .per_en(per_en), .per_we(per_we), .per_dout(per_dout), .cpu(cpu),
    .cpu_dout(cpu_dout), .dma_en(dma_en), .dma_addr(dma_addr)
  );

  dma_probe_monitor i_mon (
    .mclk(mclk), .puc_rst(puc_rst), .per_addr(per_addr), .per_din(per_din),
    .per_en(per_en), .per_we(per_we), .per_dout(per_dout), .cpu(cpu),
    .cpu_dout(cpu_dout), .dma_en(dma_en), .dma_addr(dma_addr), .err_cnt(mon_errs)
  );

  // ====================
  // Clock, reset, timeout
  // ====================
  initial begin
    mclk     = 1'b0;
    puc_rst  = 1'b1;
    per_addr = '0;
    per_din  = '0;
    per_en   = 1'b0;
    per_we   = 2'b00;
    cpu      = '0;
    forever #10 mclk = ~mclk;
  end

  always @(posedge mclk) begin
    cycles <= cycles + 1;
    if (cycles >= LIMIT) begin
      $display("Timeout: run exceeded %0d cycles without finishing", LIMIT);
      $display("Simulation failed");
      $finish;
    end
  end

  task automatic per_write(input per_addr_t a, input word_t d);
    @(posedge mclk);
    per_en   <= 1'b1;
    per_we   <= 2'b11;
    per_addr <= a;
    per_din  <= d;
    @(posedge mclk);           // Write edge
    per_en <= 1'b0;
    per_we <= 2'b00;
  endtask

  task automatic per_read(input per_addr_t a, output word_t d);
    @(posedge mclk);
    per_en   <= 1'b1;
    per_we   <= 2'b00;
    per_addr <= a;
    @(posedge mclk);
    d = per_dout;              // Still the value of the read cycle
    per_en <= 1'b0;
  endtask

  task automatic expect_word(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
      $display("CHECK FAILED %s: got 0x%04h expected 0x%04h", name, got, exp);
      tb_errs++;
    end
  endtask

  // ====================
  // Scenarios
  // ====================
  initial begin
    word_t rd;
    word_t exp_tr;
    tb_errs = 0;
    cycles  = 0;
    seed    = 32'h2f00_1508;
    rows[0] = '{target: 16'h0010, delay: 4'd3, mask: 16'hffff, bank: 1'b0};
    rows[1] = '{target: 16'h0022, delay: 4'd1, mask: 16'ha5c3, bank: 1'b0};
    rows[2] = '{target: 16'h0046, delay: 4'd8, mask: 16'h0ff1, bank: 1'b1};
    rows[3] = '{target: 16'h0058, delay: 4'd5, mask: 16'h8001, bank: 1'b0};
    for (int r = 4; r < ROWS; r++) begin
      rows[r].target = word_t'($random(seed)) & 16'h00fe;
      rows[r].delay  = 4'd1 + 4'($random(seed) & 7);
      rows[r].mask   = 16'($random(seed));
      rows[r].bank   = 1'($random(seed));
    end

    repeat (RST_CYC) @(posedge mclk);
    puc_rst <= 1'b0;

    // Reset values and decode
    per_read(A_ADDR, rd);
    expect_word("per_dout ADDR", rd, 16'h0000);
    per_read(A_CNT, rd);
    expect_word("per_dout CNT", rd, 16'h0000);
    per_read(A_TRACE, rd);
    expect_word("per_dout TRACE", rd, 16'h0000);
    per_read(14'h0040, rd);                          // Outside the window
    per_read(A_ADDR + 14'd3, rd);                    // Hole in the map

    // Zero write during the wait cancels the burst
    per_write(A_CNT, 16'd6);
    per_write(A_CNT, 16'd0);
    repeat (12) @(posedge mclk);
    per_read(A_CNT, rd);

    for (int r = 0; r < ROWS; r++) begin
      per_write(A_ADDR, rows[r].target);
      per_read(A_ADDR, rd);
      expect_word("per_dout ADDR", rd, rows[r].target);
      per_write(A_CNT, word_t'(rows[r].delay));
      repeat (rows[r].delay) @(posedge mclk);       // First burst cycle opens here
      for (int i = 0; i < BURST_LEN; i++) begin
        if (i > 0) @(posedge mclk);
        cpu.en   <= rows[r].mask[BURST_LEN-1-i];
        cpu.we   <= (i % 2 == 0) ? 2'b11 : 2'b00;  // Write, then read it back
        cpu.addr <= waddr_t'((((r * 4) + (i / 2)) % 32) * 2 + rows[r].bank);
        cpu.din  <= word_t'({r[7:0], i[7:0]}) ^ 16'h5a00;
      end
      @(posedge mclk);
      cpu.en <= 1'b0;
      while (dma_en !== 1'b0) @(posedge mclk);
      per_read(A_TRACE, rd);
      exp_tr = (rows[r].bank == rows[r].target[1]) ? rows[r].mask : 16'h0000;
      expect_word("trace", rd, exp_tr);
      per_read(A_CNT, rd);
      expect_word("per_dout CNT", rd, 16'hffff);
    end

    repeat (2) @(posedge mclk);
    $display("Errors: monitor %0d, testbench %0d", mon_errs, tb_errs);
    if (mon_errs == 0 && tb_errs == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verilog/bank_arbiter.sv */
`timescale 1ns/100ps
`default_nettype none

module bank_arbiter import dma_probe_pkg::*; (
  input  wire                       mclk,
  input  cpu_req_t                  cpu,
  input  dma_req_t                  dma,
  output logic                      dma_ready,
  output logic [BANK_CNT-1:0]       bank_en,
  output logic [BANK_CNT-1:0][1:0]  bank_we,
  output waddr_t [BANK_CNT-1:0]     bank_addr,
  output word_t  [BANK_CNT-1:0]     bank_din,
  input  word_t  [BANK_CNT-1:0]     bank_dout,
  output word_t                     cpu_dout
);

  bank_t cpu_bank;     // Bank hit by the CPU this cycle
  bank_t dma_bank;
  bank_t cpu_bank_q;   // Bank of last cycle's CPU access
  logic  collide;

  assign cpu_bank = cpu.addr[BANK_BIT +: BANK_W];
  assign dma_bank = dma.addr[BANK_BIT +: BANK_W];

  // ====================
  // Collision
  // ====================

  // Same bank, same cycle, both asking
  assign collide   = cpu.en & dma.en & (cpu_bank == dma_bank);
  assign dma_ready = ~collide;

  // ====================
  // Bank steering
  // ====================

  always_comb begin
    logic cpu_hit;
    logic dma_hit;
    for (int b = 0; b < BANK_CNT; b++) begin
      cpu_hit = cpu.en & (cpu_bank == bank_t'(b));
      dma_hit = dma.en & (dma_bank == bank_t'(b)) & ~cpu_hit;  // CPU wins

      bank_en[b]   = cpu_hit | dma_hit;
      bank_we[b]   = cpu_hit ? cpu.we : 2'b00;     // DMA only reads
      bank_addr[b] = cpu_hit ? cpu.addr : dma.addr;
      bank_din[b]  = cpu.din;                      // Only written on a CPU hit
    end
  end

  // ====================
  // CPU read return
  // ====================

  // RAM answers one cycle late, so remember the bank
  always_ff @(posedge mclk) begin
    cpu_bank_q <= cpu_bank;
  end

  assign cpu_dout = bank_dout[cpu_bank_q];

endmodule

`default_nettype wire

/* verilog/data_ram.sv */
`timescale 1ns/100ps
`default_nettype none

module data_ram import dma_probe_pkg::*; (
  input  wire                       mclk,
  input  wire  [BANK_CNT-1:0]       bank_en,
  input  wire  [BANK_CNT-1:0][1:0]  bank_we,
  input  waddr_t [BANK_CNT-1:0]     bank_addr,
  input  word_t  [BANK_CNT-1:0]     bank_din,
  output word_t  [BANK_CNT-1:0]     bank_dout
);

  // ====================
  // One array per bank
  // ====================

  for (genvar b = 0; b < BANK_CNT; b++) begin : g_bank
    word_t             mem [RAM_DEPTH];
    logic [RAM_IW-1:0] idx;

    // Bank bit is the LSB, index starts above it
    assign idx = bank_addr[b][BANK_W +: RAM_IW];

    always_ff @(posedge mclk) begin
      if (bank_en[b]) begin
        if (bank_we[b][0]) mem[idx][7:0]  <= bank_din[b][7:0];   // Low byte
        if (bank_we[b][1]) mem[idx][15:8] <= bank_din[b][15:8];  // High byte
        if (bank_we[b] == 2'b00) begin
          bank_dout[b] <= mem[idx];        // Registered read
        end
      end
    end
  end

endmodule

`default_nettype wire

/* verilog/dma_probe_pkg.sv */
`default_nettype none

package dma_probe_pkg;

  // ====================
  // Peripheral bus and register map
  // ====================
  localparam int PER_AW  = 14;                // Peripheral word address width
  localparam logic [PER_AW:0] BASE_ADDR = 15'h0070;  // Byte base, aligned to DEC_WD
  localparam int DEC_WD  = 3;                 // Address bits seen by the decoder
  localparam int DEC_SZ  = 1 << DEC_WD;       // One-hot decode width

  // Byte offsets inside the probe window
  localparam logic [DEC_WD-1:0] REG_ADDR  = 3'h0;
  localparam logic [DEC_WD-1:0] REG_CNT   = 3'h2;
  localparam logic [DEC_WD-1:0] REG_TRACE = 3'h4;

  // One-hot positions of each register
  localparam logic [DEC_SZ-1:0] REG_ADDR_D  = DEC_SZ'(1) << REG_ADDR;
  localparam logic [DEC_SZ-1:0] REG_CNT_D   = DEC_SZ'(1) << REG_CNT;
  localparam logic [DEC_SZ-1:0] REG_TRACE_D = DEC_SZ'(1) << REG_TRACE;

  // ====================
  // Burst and RAM geometry
  // ====================
  localparam int BURST_LEN = 16;              // Request cycles per burst
  localparam int RAM_AW    = 15;              // Word address, addr[15:1]
  localparam int BANK_BIT  = 0;               // Even/odd word picks the bank
  localparam int BANK_CNT  = 2;
  localparam int BANK_W    = $clog2(BANK_CNT);
  localparam int RAM_DEPTH = 64;              // Words per bank
  localparam int RAM_IW    = $clog2(RAM_DEPTH);

  typedef logic [PER_AW-1:0]            per_addr_t;
  typedef logic [15:0]                  word_t;
  typedef logic [RAM_AW-1:0]            waddr_t;
  typedef logic [BURST_LEN-1:0]         trace_t;     // One stall bit per burst cycle
  typedef logic [$clog2(BURST_LEN)-1:0] burst_cnt_t;
  typedef logic [BANK_W-1:0]            bank_t;

  typedef enum logic [1:0] {
    SEQ_IDLE,
    SEQ_WAIT,    // Delay countdown
    SEQ_BURST,   // DMA request held
    SEQ_DONE
  } seq_state_t;

  // CPU side port, fixed priority on the RAM
  typedef struct packed {
    logic       en;
    logic [1:0] we;    // Byte write enables, zero for read
    waddr_t     addr;
    word_t      din;
  } cpu_req_t;

  // Probe read request
  typedef struct packed {
    logic   en;
    waddr_t addr;
  } dma_req_t;

  // Register block to sequencer
  typedef struct packed {
    waddr_t target;
    logic   cnt_wr;    // Single cycle pulse on CNT write
    word_t  cnt_val;
  } probe_cfg_t;

  // Sequencer back to register block
  typedef struct packed {
    word_t  cnt;
    trace_t trace;
  } probe_stat_t;

endpackage

`default_nettype wire

/* verilog/dma_probe_regs.sv */
`timescale 1ns/100ps
`default_nettype none

module dma_probe_regs import dma_probe_pkg::*; (
  input  wire         mclk,
  input  wire         puc_rst,
  input  per_addr_t   per_addr,
  input  word_t       per_din,
  input  wire         per_en,
  input  wire   [1:0] per_we,
  output word_t       per_dout,
  output probe_cfg_t  cfg,
  input  probe_stat_t stat
);

  // ====================
  // Address decode
  // ====================

  logic              reg_sel;    // Access falls in the probe window
  logic [DEC_WD-1:0] reg_addr;   // Byte offset inside the window
  logic [DEC_SZ-1:0] reg_dec;
  logic              reg_write;
  logic              reg_read;
  logic [DEC_SZ-1:0] reg_wr;
  logic [DEC_SZ-1:0] reg_rd;
  word_t             addr_reg;   // ADDR register, byte address

  // Word address bits above the decoder against the byte base
  assign reg_sel  = per_en & (per_addr[PER_AW-1:DEC_WD-1] == BASE_ADDR[PER_AW:DEC_WD]);
  assign reg_addr = {per_addr[DEC_WD-2:0], 1'b0};  // Back to byte offset

  // Only the three known offsets light a bit
  assign reg_dec = (REG_ADDR_D  & {DEC_SZ{reg_addr == REG_ADDR}})
                 | (REG_CNT_D   & {DEC_SZ{reg_addr == REG_CNT}})
                 | (REG_TRACE_D & {DEC_SZ{reg_addr == REG_TRACE}});

  assign reg_write =  (|per_we) & reg_sel;
  assign reg_read  = ~(|per_we) & reg_sel;

  assign reg_wr = reg_dec & {DEC_SZ{reg_write}};
  assign reg_rd = reg_dec & {DEC_SZ{reg_read}};

  // ====================
  // Registers
  // ====================

  // Target address, written as a byte address
  always_ff @(posedge mclk or posedge puc_rst) begin
    if (puc_rst) begin
      addr_reg <= '0;
    end else if (reg_wr[REG_ADDR]) begin
      addr_reg <= per_din;
    end
  end

  // CNT itself lives in the sequencer
  assign cfg.cnt_wr  = reg_wr[REG_CNT];         // High only in the write cycle
  assign cfg.cnt_val = per_din;
  assign cfg.target  = addr_reg[15:1];          // Drop byte bit

  // ====================
  // Read-back
  // ====================

  // Zero when unselected or on a hole in the map
  assign per_dout = ({$bits(word_t){reg_rd[REG_ADDR]}}  & addr_reg)
                  | ({$bits(word_t){reg_rd[REG_CNT]}}   & stat.cnt)
                  | ({$bits(word_t){reg_rd[REG_TRACE]}} & word_t'(stat.trace));

endmodule

`default_nettype wire

/* verilog/dma_probe_seq.sv */
`timescale 1ns/100ps
`default_nettype none

module dma_probe_seq import dma_probe_pkg::*; (
  input  wire         mclk,
  input  wire         puc_rst,
  input  probe_cfg_t  cfg,
  output probe_stat_t stat,
  output dma_req_t    dma,
  input  wire         dma_ready
);

  seq_state_t state;
  word_t      delay_cnt;    // Doubles as the CNT read value
  burst_cnt_t burst_cnt;
  trace_t     trace;
  logic       wait_last;    // Final delay cycle
  logic       burst_last;   // Final request cycle

  assign wait_last  = (state == SEQ_WAIT)  && (delay_cnt == word_t'(1));
  assign burst_last = (state == SEQ_BURST) && (burst_cnt == burst_cnt_t'(BURST_LEN - 1));

  // ====================
  // State machine
  // ====================

  always_ff @(posedge mclk or posedge puc_rst) begin
    if (puc_rst) begin
      state <= SEQ_IDLE;
    end else if (cfg.cnt_wr) begin
      // Any CNT write restarts, even mid burst
      state <= (cfg.cnt_val == '0) ? SEQ_IDLE : SEQ_WAIT;
    end else begin
      case (state)
        SEQ_WAIT:  if (wait_last)  state <= SEQ_BURST;
        SEQ_BURST: if (burst_last) state <= SEQ_DONE;
        default:   state <= state;                 // IDLE and DONE hold
      endcase
    end
  end

  // ====================
  // Delay counter
  // ====================

  // N loaded on the write edge, burst starts N edges later
  always_ff @(posedge mclk or posedge puc_rst) begin
    if (puc_rst) begin
      delay_cnt <= '0;
    end else if (cfg.cnt_wr) begin
      delay_cnt <= cfg.cnt_val;
    end else if (state == SEQ_WAIT) begin
      delay_cnt <= delay_cnt - word_t'(1);         // Reaches 0 as burst opens
    end else if (burst_last) begin
      delay_cnt <= '1;                             // Done marker
    end
  end

  // ====================
  // Burst counter
  // ====================

  always_ff @(posedge mclk or posedge puc_rst) begin
    if (puc_rst) begin
      burst_cnt <= '0;
    end else if (cfg.cnt_wr) begin
      burst_cnt <= '0;
    end else if (state == SEQ_BURST) begin
      burst_cnt <= burst_cnt + burst_cnt_t'(1);    // Wraps to 0 on the last cycle
    end
  end

  // ====================
  // Stall trace
  // ====================

  // First burst cycle ends up in the MSB
  always_ff @(posedge mclk or posedge puc_rst) begin
    if (puc_rst) begin
      trace <= '0;
    end else if ((state == SEQ_BURST) && !cfg.cnt_wr) begin
      trace <= {trace[BURST_LEN-2:0], ~dma_ready};
    end
  end

  // Stall never stretches the burst
  assign dma.en   = (state == SEQ_BURST);
  assign dma.addr = cfg.target;

  assign stat.cnt   = delay_cnt;
  assign stat.trace = trace;

endmodule

`default_nettype wire

/* verilog/dma_probe_top.sv */
`timescale 1ns/100ps
`default_nettype none

module dma_probe_top import dma_probe_pkg::*; (
  input  wire        mclk,
  input  wire        puc_rst,
  input  per_addr_t  per_addr,
  input  word_t      per_din,
  input  wire        per_en,
  input  wire  [1:0] per_we,
  output word_t      per_dout,
  input  cpu_req_t   cpu,
  output word_t      cpu_dout,
  output logic       dma_en,
  output waddr_t     dma_addr
);

  probe_cfg_t  cfg;
  probe_stat_t stat;
  dma_req_t    dma;
  logic        dma_ready;

  // RAM side of the arbiter
  logic [BANK_CNT-1:0]       bank_en;
  logic [BANK_CNT-1:0][1:0]  bank_we;
  waddr_t [BANK_CNT-1:0]     bank_addr;
  word_t  [BANK_CNT-1:0]     bank_din;
  word_t  [BANK_CNT-1:0]     bank_dout;

  // ====================
  // Probe
  // ====================

  dma_probe_regs i_regs (
    .mclk     (mclk),
    .puc_rst  (puc_rst),
    .per_addr (per_addr),
    .per_din  (per_din),
    .per_en   (per_en),
    .per_we   (per_we),
    .per_dout (per_dout),
    .cfg      (cfg),
    .stat     (stat)
  );

  dma_probe_seq i_seq (
    .mclk      (mclk),
    .puc_rst   (puc_rst),
    .cfg       (cfg),
    .stat      (stat),
    .dma       (dma),
    .dma_ready (dma_ready)
  );

  // ====================
  // Memory side
  // ====================

  bank_arbiter i_arb (
    .mclk      (mclk),
    .cpu       (cpu),
    .dma       (dma),
    .dma_ready (dma_ready),
    .bank_en   (bank_en),
    .bank_we   (bank_we),
    .bank_addr (bank_addr),
    .bank_din  (bank_din),
    .bank_dout (bank_dout),
    .cpu_dout  (cpu_dout)
  );

  data_ram i_ram (
    .mclk      (mclk),
    .bank_en   (bank_en),
    .bank_we   (bank_we),
    .bank_addr (bank_addr),
    .bank_din  (bank_din),
    .bank_dout (bank_dout)
  );

  assign dma_en   = dma.en;     // Exported for observation
  assign dma_addr = dma.addr;

endmodule

`default_nettype wire
